// File: logic/mips_back_pkg.sv
// shared types for the mem/wb back end; byte lanes are little-endian, lane n = addr[1:0]
package mips_back_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        mem_none = 4'd0,
        mem_lb   = 4'd1,
        mem_lbu  = 4'd2,
        mem_lh   = 4'd3,
        mem_lhu  = 4'd4,
        mem_lw   = 4'd5,
        mem_sb   = 4'd6,
        mem_sh   = 4'd7,
        mem_sw   = 4'd8,
        mem_ll   = 4'd9,
        mem_sc   = 4'd10
    } mem_op_t;

    // one ram word seen as byte lanes, halfword lanes or a whole word
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
        word_t            word;
    } data_word_u;

    typedef struct packed {
        word_t     pc;
        mem_op_t   op;
        word_t     addr;
        word_t     store_data;
        reg_addr_t wd;
        logic      wreg;
        word_t     wdata;
        word_t     hi;
        word_t     lo;
        logic      whilo;
        logic      cp0_we;
        reg_addr_t cp0_addr;
        word_t     cp0_data;
    } mem_in_t;

    typedef struct packed {
        reg_addr_t wd;
        logic      wreg;
        word_t     wdata;
        word_t     hi;
        word_t     lo;
        logic      whilo;
        logic      llbit_we;
        logic      llbit_value;
        logic      cp0_we;
        reg_addr_t cp0_addr;
        word_t     cp0_data;
        logic      exc_we;
        word_t     exc_pc;
        word_t     exc_badvaddr;
    } wb_rec_t;

    // bit order pc, if, id, ex, mem, wb
    typedef logic [5:0] stall_vec_t;

    localparam int stall_mem = 4;
    localparam int stall_wb  = 5;

    localparam reg_addr_t cp0_status_addr   = 5'd12;
    localparam reg_addr_t cp0_epc_addr      = 5'd14;
    localparam reg_addr_t cp0_badvaddr_addr = 5'd8;

endpackage

// File: logic/pipe_ctrl.sv
// stall requests are levels; flush follows exc_req in the same cycle and beats every stall
module pipe_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall_req_ex,
    input  logic                      stall_req_mem,
    input  logic                      exc_req,
    output mips_back_pkg::stall_vec_t stall,
    output logic                      flush
);
    import mips_back_pkg::*;

    logic drop_q;
    logic req_ex;
    logic req_mem;

    // a request seen with a flush came from the flushed instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_q <= 1'b0;
        end else begin
            drop_q <= exc_req && (stall_req_ex || stall_req_mem);
        end
    end

    // so ignore it once more after the flush
    assign req_ex  = stall_req_ex && !drop_q;
    assign req_mem = stall_req_mem && !drop_q;

    always_comb begin
        stall = '0;
        if (exc_req) begin
            stall = '0;
        end else if (req_mem) begin
            // mem and everything before it hold, wb takes a bubble
            stall[stall_mem:0] = '1;
        end else if (req_ex) begin
            stall[stall_mem-1:0] = '1;
        end
    end

    assign flush = exc_req;

endmodule

// File: logic/data_ram.sv
// combinational read, byte-lane write at the clock edge; contents are not cleared by reset
module data_ram #(
    parameter int ram_words = 64
) (
    input  logic                          clk,
    input  logic [3:0]                    we,
    input  logic [$clog2(ram_words)-1:0]  addr,
    input  mips_back_pkg::data_word_u     wdata,
    output mips_back_pkg::data_word_u     rdata
);
    import mips_back_pkg::*;

    data_word_u mem [0:ram_words-1];

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (we[lane]) begin
                mem[addr].bytes[lane] <= wdata.bytes[lane];
            end
        end
    end

    // write of the previous edge is already visible here
    assign rdata = mem[addr];

endmodule

// File: logic/mem_stage.sv
// purely combinational; address bits above the ram size are ignored, so accesses wrap
module mem_stage #(
    parameter int ram_words = 64
) (
    input  mips_back_pkg::mem_in_t        mem_in,
    input  logic                          hold,
    input  logic                          llbit_now,
    input  mips_back_pkg::data_word_u     ram_rdata,
    output logic [$clog2(ram_words)-1:0]  ram_addr,
    output logic [3:0]                    ram_we,
    output mips_back_pkg::data_word_u     ram_wdata,
    output logic                          exc_req,
    output mips_back_pkg::wb_rec_t        mem_rec
);
    import mips_back_pkg::*;

    localparam int aw = $clog2(ram_words);

    logic [1:0]  lane;
    logic        misaligned;
    logic [3:0]  store_en;
    logic [7:0]  load_byte;
    logic [15:0] load_half;
    word_t       load_data;
    logic        cp0_writable;

    assign lane     = mem_in.addr[1:0];
    assign ram_addr = mem_in.addr[aw+1:2];

    // same ram word decoded two ways
    assign load_byte = ram_rdata.bytes[lane];
    assign load_half = ram_rdata.halves[lane[1]];

    always_comb begin
        case (mem_in.op)
            mem_lh, mem_lhu, mem_sh: begin
                misaligned = lane[0];
            end
            mem_lw, mem_sw, mem_ll, mem_sc: begin
                misaligned = (lane != 2'b00);
            end
            default: begin
                misaligned = 1'b0;
            end
        endcase
    end

    assign exc_req = misaligned;

    // replicate store data into every lane, enables pick the real ones
    always_comb begin
        ram_wdata.word = mem_in.store_data;
        case (mem_in.op)
            mem_sb: begin
                store_en        = 4'b0001 << lane;
                ram_wdata.bytes = {4{mem_in.store_data[7:0]}};
            end
            mem_sh: begin
                store_en         = lane[1] ? 4'b1100 : 4'b0011;
                ram_wdata.halves = {2{mem_in.store_data[15:0]}};
            end
            mem_sw: begin
                store_en = 4'b1111;
            end
            mem_sc: begin
                // conditional on a live link
                store_en = llbit_now ? 4'b1111 : 4'b0000;
            end
            default: begin
                store_en = 4'b0000;
            end
        endcase
    end

    assign ram_we = (hold || exc_req) ? 4'b0000 : store_en;

    always_comb begin
        case (mem_in.op)
            mem_lb:         load_data = {{24{load_byte[7]}}, load_byte};
            mem_lbu:        load_data = {24'd0, load_byte};
            mem_lh:         load_data = {{16{load_half[15]}}, load_half};
            mem_lhu:        load_data = {16'd0, load_half};
            mem_lw, mem_ll: load_data = ram_rdata.word;
            mem_sc:         load_data = {31'd0, llbit_now};
            default:        load_data = mem_in.wdata;
        endcase
    end

    // badvaddr is read-only to mtc0
    assign cp0_writable = (mem_in.cp0_addr != cp0_badvaddr_addr);

    always_comb begin
        mem_rec.wd           = mem_in.wd;
        mem_rec.wreg         = mem_in.wreg && !exc_req;
        mem_rec.wdata        = load_data;
        mem_rec.hi           = mem_in.hi;
        mem_rec.lo           = mem_in.lo;
        mem_rec.whilo        = mem_in.whilo;
        mem_rec.llbit_we     = (mem_in.op == mem_ll) || (mem_in.op == mem_sc);
        mem_rec.llbit_value  = (mem_in.op == mem_ll);
        mem_rec.cp0_we       = mem_in.cp0_we && cp0_writable;
        mem_rec.cp0_addr     = mem_in.cp0_addr;
        mem_rec.cp0_data     = mem_in.cp0_data;
        mem_rec.exc_we       = exc_req;
        mem_rec.exc_pc       = mem_in.pc;
        mem_rec.exc_badvaddr = mem_in.addr;
    end

endmodule

// File: logic/mem_wb.sv
// flush wins over stall; a mem stall with wb running leaves a bubble without strobes
module mem_wb (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  mips_back_pkg::stall_vec_t stall,
    input  mips_back_pkg::wb_rec_t    mem_rec,
    input  mips_back_pkg::word_t      exc_pc,
    input  mips_back_pkg::word_t      exc_badvaddr,
    output mips_back_pkg::wb_rec_t    wb_rec
);
    import mips_back_pkg::*;

    wb_rec_t flush_rec;

    // empty record, only the exception capture
    always_comb begin
        flush_rec              = '0;
        flush_rec.exc_we       = 1'b1;
        flush_rec.exc_pc       = exc_pc;
        flush_rec.exc_badvaddr = exc_badvaddr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_rec <= '0;
        end else if (flush) begin
            wb_rec <= flush_rec;
        end else if (stall[stall_mem] && !stall[stall_wb]) begin
            wb_rec <= '0;
        end else if (!stall[stall_mem]) begin
            wb_rec <= mem_rec;
        end
    end

endmodule

// File: logic/wb_state.sv
// CP0 subset is status, epc, badvaddr only; an exception does not touch status
module wb_state (
    input  logic                   clk,
    input  logic                   rst,
    input  mips_back_pkg::wb_rec_t wb_rec,
    output logic                   llbit_now,
    output mips_back_pkg::word_t   hi,
    output mips_back_pkg::word_t   lo,
    output mips_back_pkg::word_t   cp0_status,
    output mips_back_pkg::word_t   cp0_epc,
    output mips_back_pkg::word_t   cp0_badvaddr,
    output logic                   llbit
);
    import mips_back_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (wb_rec.whilo) begin
            hi <= wb_rec.hi;
            lo <= wb_rec.lo;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            llbit <= 1'b0;
        end else if (wb_rec.exc_we) begin
            llbit <= 1'b0;
        end else if (wb_rec.llbit_we) begin
            llbit <= wb_rec.llbit_value;
        end
    end

    // forward the pending writeback so SC right after LL sees the link
    always_comb begin
        if (wb_rec.exc_we) begin
            llbit_now = 1'b0;
        end else if (wb_rec.llbit_we) begin
            llbit_now = wb_rec.llbit_value;
        end else begin
            llbit_now = llbit;
        end
    end

    // exception capture before mtc0
    always_ff @(posedge clk) begin
        if (rst) begin
            cp0_status   <= '0;
            cp0_epc      <= '0;
            cp0_badvaddr <= '0;
        end else if (wb_rec.exc_we) begin
            cp0_epc      <= wb_rec.exc_pc;
            cp0_badvaddr <= wb_rec.exc_badvaddr;
        end else if (wb_rec.cp0_we) begin
            case (wb_rec.cp0_addr)
                cp0_status_addr: begin
                    cp0_status <= wb_rec.cp0_data;
                end
                cp0_epc_addr: begin
                    cp0_epc <= wb_rec.cp0_data;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: logic/mem_back_top.sv
// mem_in must be held upstream while stall[4] is high; the register file write is output only
module mem_back_top #(
    parameter int ram_words = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  mips_back_pkg::mem_in_t    mem_in,
    input  logic                      stall_req_ex,
    input  logic                      stall_req_mem,
    output logic                      rf_we,
    output mips_back_pkg::reg_addr_t  rf_addr,
    output mips_back_pkg::word_t      rf_data,
    output mips_back_pkg::word_t      hi,
    output mips_back_pkg::word_t      lo,
    output logic                      llbit,
    output mips_back_pkg::word_t      cp0_status,
    output mips_back_pkg::word_t      cp0_epc,
    output mips_back_pkg::word_t      cp0_badvaddr,
    output mips_back_pkg::stall_vec_t stall,
    output logic                      flush
);
    import mips_back_pkg::*;

    logic [$clog2(ram_words)-1:0] ram_addr;
    logic [3:0]                   ram_we;
    data_word_u                   ram_wdata;
    data_word_u                   ram_rdata;
    logic                         exc_req;
    logic                         llbit_now;
    wb_rec_t                      mem_rec;
    wb_rec_t                      wb_rec;

    pipe_ctrl u_pipe_ctrl (
        .clk           (clk),
        .rst           (rst),
        .stall_req_ex  (stall_req_ex),
        .stall_req_mem (stall_req_mem),
        .exc_req       (exc_req),
        .stall         (stall),
        .flush         (flush)
    );

    data_ram #(.ram_words(ram_words)) u_data_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mem_stage #(.ram_words(ram_words)) u_mem_stage (
        .mem_in    (mem_in),
        .hold      (stall[stall_mem]),
        .llbit_now (llbit_now),
        .ram_rdata (ram_rdata),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_wdata (ram_wdata),
        .exc_req   (exc_req),
        .mem_rec   (mem_rec)
    );

    mem_wb u_mem_wb (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .stall        (stall),
        .mem_rec      (mem_rec),
        .exc_pc       (mem_rec.exc_pc),
        .exc_badvaddr (mem_rec.exc_badvaddr),
        .wb_rec       (wb_rec)
    );

    wb_state u_wb_state (
        .clk          (clk),
        .rst          (rst),
        .wb_rec       (wb_rec),
        .llbit_now    (llbit_now),
        .hi           (hi),
        .lo           (lo),
        .cp0_status   (cp0_status),
        .cp0_epc      (cp0_epc),
        .cp0_badvaddr (cp0_badvaddr),
        .llbit        (llbit)
    );

    assign rf_we   = wb_rec.wreg;
    assign rf_addr = wb_rec.wd;
    assign rf_data = wb_rec.wdata;

endmodule

// File: verification/mem_back_properties.sv
// strobe checks on the writeback record; inputs a bind target lacks are tied inactive
module mem_back_properties (
    input logic                      clk,
    input logic                      rst,
    input logic                      flush,
    input mips_back_pkg::stall_vec_t stall,
    input mips_back_pkg::wb_rec_t    wb_rec,
    input logic                      llbit
);
    import mips_back_pkg::*;

    logic strobes;

    assign strobes = wb_rec.wreg || wb_rec.whilo || wb_rec.llbit_we
                     || wb_rec.cp0_we || wb_rec.exc_we;

    // first record loaded once reset is released
    quiet_after_reset: assert property (@(posedge clk) $fell(rst) |=> !strobes)
        else $error("write strobe active in the first cycle after reset");

    // flush record never writes the register file
    flush_kills_write: assert property (@(posedge clk) disable iff (rst)
        flush |=> !wb_rec.wreg)
        else $error("register write in the cycle after a flush");

    wb_never_stalls: assert property (@(posedge clk) disable iff (rst) !stall[stall_wb])
        else $error("writeback stage stalled");

    exc_clears_link: assert property (@(posedge clk) disable iff (rst)
        wb_rec.exc_we |=> !llbit)
        else $error("link bit still set after an exception");

endmodule

bind mem_wb mem_back_properties u_mem_wb_props (
    .clk    (clk),
    .rst    (rst),
    .flush  (flush),
    .stall  (stall),
    .wb_rec (wb_rec),
    .llbit  (1'b0)
);

bind wb_state mem_back_properties u_wb_state_props (
    .clk    (clk),
    .rst    (rst),
    .flush  (1'b0),
    .stall  (6'b000000),
    .wb_rec (wb_rec),
    .llbit  (llbit)
);

// File: verification/mem_back_tb.sv
// run from the project root so the stimulus file path resolves; one stimulus line per cycle
module mem_back_tb;
    import mips_back_pkg::*;

    typedef struct packed {
        mem_in_t    mem_in;
        logic       req_ex;
        logic       req_mem;
        logic       rf_we;
        reg_addr_t  rf_addr;
        word_t      rf_data;
        word_t      hi;
        word_t      lo;
        logic       llbit;
        word_t      status;
        word_t      epc;
        word_t      badvaddr;
        stall_vec_t stall;
        logic       flush;
    } stim_row_t;

    logic       clk;
    logic       rst;
    mem_in_t    mem_in;
    logic       stall_req_ex;
    logic       stall_req_mem;
    logic       rf_we;
    reg_addr_t  rf_addr;
    word_t      rf_data;
    word_t      hi;
    word_t      lo;
    logic       llbit;
    word_t      cp0_status;
    word_t      cp0_epc;
    word_t      cp0_badvaddr;
    stall_vec_t stall;
    logic       flush;

    stim_row_t rows[$];
    logic      stim_opened;
    logic      stim_loaded;
    int        errors;
    int        checks;
    int        cycle_count;
    int        cycle_limit;

    mem_back_top #(.ram_words(64)) u_dut (
        .clk           (clk),
        .rst           (rst),
        .mem_in        (mem_in),
        .stall_req_ex  (stall_req_ex),
        .stall_req_mem (stall_req_mem),
        .rf_we         (rf_we),
        .rf_addr       (rf_addr),
        .rf_data       (rf_data),
        .hi            (hi),
        .lo            (lo),
        .llbit         (llbit),
        .cp0_status    (cp0_status),
        .cp0_epc       (cp0_epc),
        .cp0_badvaddr  (cp0_badvaddr),
        .stall         (stall),
        .flush         (flush)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic load_stim();
        int          fd;
        int          n;
        string       text;
        logic [31:0] f [0:25];
        stim_row_t   row;
        fd = $fopen("verification/mem_back_stim.txt", "r");
        stim_opened = (fd != 0);
        if (stim_opened) begin
            while (!$feof(fd)) begin
                text = "";
                void'($fgets(text, fd));
                if (text.len() < 2 || text.substr(0, 1) == "//") begin
                    continue;
                end
                n = $sscanf(text,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                    f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                    f[22], f[23], f[24], f[25]);
                if (n != 26) begin
                    $display("stimulus line has %0d fields instead of 26: %s", n, text);
                    errors++;
                    continue;
                end
                row = '0;
                row.mem_in.pc         = f[0];
                row.mem_in.op         = mem_op_t'(f[1][3:0]);
                row.mem_in.addr       = f[2];
                row.mem_in.store_data = f[3];
                row.mem_in.wd         = f[4][4:0];
                row.mem_in.wreg       = f[5][0];
                row.mem_in.wdata      = f[6];
                row.mem_in.hi         = f[7];
                row.mem_in.lo         = f[8];
                row.mem_in.whilo      = f[9][0];
                row.mem_in.cp0_we     = f[10][0];
                row.mem_in.cp0_addr   = f[11][4:0];
                row.mem_in.cp0_data   = f[12];
                row.req_ex            = f[13][0];
                row.req_mem           = f[14][0];
                row.rf_we             = f[15][0];
                row.rf_addr           = f[16][4:0];
                row.rf_data           = f[17];
                row.hi                = f[18];
                row.lo                = f[19];
                row.llbit             = f[20][0];
                row.status            = f[21];
                row.epc               = f[22];
                row.badvaddr          = f[23];
                row.stall             = f[24][5:0];
                row.flush             = f[25][0];
                rows.push_back(row);
            end
            $fclose(fd);
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // address and data only matter when the write strobe is up
    task automatic check_wb(input logic got_we, input reg_addr_t got_addr, input word_t got_data,
                            input logic exp_we, input reg_addr_t exp_addr, input word_t exp_data);
        check_bit(got_we, exp_we, "rf_we");
        if (exp_we) begin
            checks++;
            if (got_addr !== exp_addr || got_data !== exp_data) begin
                errors++;
                $display("error at %0t: rf write r%0d = %h, expected r%0d = %h",
                         $time, got_addr, got_data, exp_addr, exp_data);
            end
        end
    endtask

    task automatic check_stall(input stall_vec_t got_stall, input logic got_flush,
                               input stall_vec_t exp_stall, input logic exp_flush);
        checks++;
        if (got_stall !== exp_stall || got_flush !== exp_flush) begin
            errors++;
            $display("error at %0t: stall %b flush %b, expected stall %b flush %b",
                     $time, got_stall, got_flush, exp_stall, exp_flush);
        end
    endtask

    task automatic check_row(input int index, input stim_row_t row);
        int errors_before;
        errors_before = errors;
        check_wb(rf_we, rf_addr, rf_data, row.rf_we, row.rf_addr, row.rf_data);
        check_word(hi, row.hi, "hi");
        check_word(lo, row.lo, "lo");
        check_bit(llbit, row.llbit, "llbit");
        check_word(cp0_status, row.status, "cp0 status");
        check_word(cp0_epc, row.epc, "cp0 epc");
        check_word(cp0_badvaddr, row.badvaddr, "cp0 badvaddr");
        check_stall(stall, flush, row.stall, row.flush);
        // held or excepting access must leave the ram alone
        if (row.stall[stall_mem] || row.flush) begin
            check_bit(|u_dut.ram_we, 1'b0, "ram write enable");
        end
        if (errors == errors_before) begin
            $display("line %0d ok", index);
        end else begin
            $display("line %0d failed with %0d errors", index, errors - errors_before);
        end
    endtask

    initial begin
        rst           = 1'b1;
        mem_in        = '0;
        stall_req_ex  = 1'b0;
        stall_req_mem = 1'b0;
        errors        = 0;
        checks        = 0;
        stim_loaded   = 1'b0;
        load_stim();
        cycle_limit = 2 * rows.size() + 20;
        stim_loaded = 1'b1;
        if (!stim_opened || rows.size() == 0) begin
            $display("stimulus file could not be opened or holds no lines");
            $display("Simulation finished: FAIL");
        end else begin
            repeat (5) @(posedge clk);
            #10;
            rst = 1'b0;
            for (int i = 0; i < rows.size(); i++) begin
                @(posedge clk);
                #10;
                mem_in        = rows[i].mem_in;
                stall_req_ex  = rows[i].req_ex;
                stall_req_mem = rows[i].req_mem;
                @(negedge clk);
                check_row(i, rows[i]);
            end
            $display("%0d lines run, %0d checks, %0d errors", rows.size(), checks, errors);
            if (errors == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
        end
        $finish;
    end

    // watchdog
    initial begin
        cycle_count = 0;
        wait (stim_loaded);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run did not end within %0d clock cycles", cycle_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: sources.f
logic/mips_back_pkg.sv
logic/pipe_ctrl.sv
logic/data_ram.sv
logic/mem_stage.sv
logic/mem_wb.sv
logic/wb_state.sv
logic/mem_back_top.sv
verification/mem_back_properties.sv
verification/mem_back_tb.sv

// File: verification/mem_back_stim.txt
// in: pc op addr store_data wd wreg wdata hi lo whilo cp0_we cp0_addr cp0_data req_ex req_mem
// expected: rf_we rf_addr rf_data hi lo llbit status epc badvaddr stall flush (all hex)
100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
104 8 40 8899aabb 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
108 5 40 0 2 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
10c 7 42 1234f00d 0 0 0 0 0 0 0 0 0 0 0 1 2 8899aabb 0 0 0 0 0 0 0 0
110 6 41 c5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
114 5 40 0 3 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
118 1 41 0 4 1 0 0 0 0 0 0 0 0 0 1 3 f00dc5bb 0 0 0 0 0 0 0 0
11c 2 41 0 5 1 0 0 0 0 0 0 0 0 0 1 4 ffffffc5 0 0 0 0 0 0 0 0
120 1 42 0 6 1 0 0 0 0 0 0 0 0 0 1 5 c5 0 0 0 0 0 0 0 0
124 3 42 0 7 1 0 0 0 0 0 0 0 0 0 1 6 d 0 0 0 0 0 0 0 0
128 4 42 0 8 1 0 0 0 0 0 0 0 0 0 1 7 fffff00d 0 0 0 0 0 0 0 0
12c 3 40 0 9 1 0 0 0 0 0 0 0 0 0 1 8 f00d 0 0 0 0 0 0 0 0
130 2 43 0 a 1 0 0 0 0 0 0 0 0 0 1 9 ffffc5bb 0 0 0 0 0 0 0 0
134 0 0 0 0 0 0 11112222 33334444 1 0 0 0 0 0 1 a f0 0 0 0 0 0 0 0 0
138 0 0 0 0 0 0 0 0 0 1 c ff01 0 0 0 0 0 0 0 0 0 0 0 0 0
13c 0 0 0 0 0 0 0 0 0 1 e abc 0 0 0 0 0 11112222 33334444 0 0 0 0 0 0
140 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11112222 33334444 0 ff01 0 0 0 0
144 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11112222 33334444 0 ff01 abc 0 0 0
148 8 48 5555aaaa 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11112222 33334444 0 ff01 abc 0 0 0
14c 9 48 0 b 1 0 0 0 0 0 0 0 0 0 0 0 0 11112222 33334444 0 ff01 abc 0 0 0
150 a 48 deadbeef c 1 0 0 0 0 0 0 0 0 0 1 b 5555aaaa 11112222 33334444 0 ff01 abc 0 0 0
154 5 48 0 d 1 0 0 0 0 0 0 0 0 0 1 c 1 11112222 33334444 1 ff01 abc 0 0 0
158 a 48 1010101 e 1 0 0 0 0 0 0 0 0 0 1 d deadbeef 11112222 33334444 0 ff01 abc 0 0 0
15c 5 48 0 f 1 0 0 0 0 0 0 0 0 0 1 e 0 11112222 33334444 0 ff01 abc 0 0 0
160 9 48 0 10 1 0 0 0 0 0 0 0 0 0 1 f deadbeef 11112222 33334444 0 ff01 abc 0 0 0
164 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 10 deadbeef 11112222 33334444 0 ff01 abc 0 0 0
168 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11112222 33334444 1 ff01 abc 0 0 0
16c 5 4a 0 11 1 0 0 0 0 0 0 0 0 0 0 0 0 11112222 33334444 1 ff01 abc 0 0 1
170 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11112222 33334444 1 ff01 abc 0 0 0
174 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11112222 33334444 0 ff01 16c 4a 0 0
178 0 0 0 12 1 77 aaaa bbbb 1 0 0 0 0 1 0 0 0 11112222 33334444 0 ff01 16c 4a 1f 0
178 0 0 0 12 1 77 aaaa bbbb 1 0 0 0 0 1 0 0 0 11112222 33334444 0 ff01 16c 4a 1f 0
178 0 0 0 12 1 77 aaaa bbbb 1 0 0 0 0 0 0 0 0 11112222 33334444 0 ff01 16c 4a 0 0
184 8 50 badf00d 0 0 0 0 0 0 0 0 0 0 1 1 12 77 11112222 33334444 0 ff01 16c 4a 1f 0
184 8 50 badf00d 0 0 0 0 0 0 0 0 0 0 1 0 0 0 aaaa bbbb 0 ff01 16c 4a 1f 0
184 8 50 badf00d 0 0 0 0 0 0 0 0 0 0 0 0 0 0 aaaa bbbb 0 ff01 16c 4a 0 0
190 5 50 0 13 1 0 0 0 0 0 0 0 0 0 0 0 0 aaaa bbbb 0 ff01 16c 4a 0 0
194 0 0 0 14 1 55 0 0 0 0 0 0 1 0 1 13 badf00d aaaa bbbb 0 ff01 16c 4a f 0
198 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 14 55 aaaa bbbb 0 ff01 16c 4a 0 0
19c 8 51 ffffffff 0 0 0 0 0 0 0 0 0 0 0 0 0 0 aaaa bbbb 0 ff01 16c 4a 0 1
1a0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 aaaa bbbb 0 ff01 16c 4a 0 0
1a4 5 50 0 15 1 0 0 0 0 0 0 0 0 0 0 0 0 aaaa bbbb 0 ff01 19c 51 0 0
1a8 0 0 0 0 0 0 0 0 0 1 8 999 0 0 1 15 badf00d aaaa bbbb 0 ff01 19c 51 0 0
1ac 3 52 0 16 1 0 0 0 0 0 0 0 0 0 0 0 0 aaaa bbbb 0 ff01 19c 51 0 0
1b0 1 51 0 17 1 0 0 0 0 0 0 0 0 0 1 16 bad aaaa bbbb 0 ff01 19c 51 0 0
1b4 0 0 0 0 0 0 0 0 0 1 c 0 0 0 1 17 fffffff0 aaaa bbbb 0 ff01 19c 51 0 0
1b8 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 aaaa bbbb 0 ff01 19c 51 0 0
1bc 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 aaaa bbbb 0 0 19c 51 0 0
